/* rv_core_defines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define SHAMT_W     5  // rv32 shift amount

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

// funct7 values
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000  // sub, sra, srai

// funct3 values, shared by OP and OP-IMM
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`endif

/* rv_core_pkg.sv */
`include "rv_core_defines.svh"

package rv_core_pkg;

  // register-register format
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_fmt_t;

  // immediate format
  typedef struct packed {
    logic [11:0]            imm12;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } i_fmt_t;

  // upper immediate format
  typedef struct packed {
    logic [19:0]            imm20;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } u_fmt_t;

  // one instruction word, three readings
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } inst_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

endpackage

/* rv_decode.sv */
`include "rv_core_defines.svh"

module rv_decode (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   inst_valid_i,
  input  logic [`XLEN-1:0]       inst_i,
  output logic                   dec_valid_o,
  output rv_core_pkg::alu_op_e   dec_alu_op_o,
  output logic [`REG_ADDR_W-1:0] dec_rs1_o,
  output logic [`REG_ADDR_W-1:0] dec_rs2_o,
  output logic [`REG_ADDR_W-1:0] dec_rd_o,
  output logic [`XLEN-1:0]       dec_imm_o,
  output logic                   dec_use_imm_o,
  output logic                   dec_wen_o,
  output logic                   dec_illegal_o
);

  rv_core_pkg::inst_u   inst_w;
  rv_core_pkg::alu_op_e alu_op_d;
  logic [`REG_ADDR_W-1:0] rs1_d;
  logic [`REG_ADDR_W-1:0] rs2_d;
  logic [`REG_ADDR_W-1:0] rd_d;
  logic [`XLEN-1:0]       imm_d;
  logic                   use_imm_d;
  logic                   legal_d;
  logic                   f7_base;
  logic                   f7_alt;
  logic [`XLEN-1:0]       imm_i_sext;
  logic [`XLEN-1:0]       imm_shamt;

  assign inst_w  = inst_i;
  assign f7_base = (inst_w.r.funct7 == `F7_BASE);
  assign f7_alt  = (inst_w.r.funct7 == `F7_ALT);

  assign imm_i_sext = {{(`XLEN-12){inst_w.i.imm12[11]}}, inst_w.i.imm12};
  assign imm_shamt  = {{(`XLEN-`SHAMT_W){1'b0}}, inst_w.r.rs2}; // shamt sits in rs2 field

  always_comb begin
    alu_op_d  = rv_core_pkg::ALU_ADD;
    rs1_d     = '0;
    rs2_d     = '0;
    rd_d      = inst_w.r.rd;
    imm_d     = '0;
    use_imm_d = 1'b0;
    legal_d   = 1'b0;
    case (inst_w.r.opcode)
      `OPC_OP: begin
        rs1_d   = inst_w.r.rs1;
        rs2_d   = inst_w.r.rs2;
        legal_d = f7_base;
        case (inst_w.r.funct3)
          `F3_ADD_SUB: begin
            alu_op_d = f7_alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            legal_d  = f7_base || f7_alt;
          end
          `F3_SRL_SRA: begin
            alu_op_d = f7_alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            legal_d  = f7_base || f7_alt;
          end
          `F3_SLL:  alu_op_d = rv_core_pkg::ALU_SLL;
          `F3_SLT:  alu_op_d = rv_core_pkg::ALU_SLT;
          `F3_SLTU: alu_op_d = rv_core_pkg::ALU_SLTU;
          `F3_XOR:  alu_op_d = rv_core_pkg::ALU_XOR;
          `F3_OR:   alu_op_d = rv_core_pkg::ALU_OR;
          default:  alu_op_d = rv_core_pkg::ALU_AND;
        endcase
      end
      `OPC_OP_IMM: begin
        rs1_d     = inst_w.i.rs1;
        use_imm_d = 1'b1;
        imm_d     = imm_i_sext;
        legal_d   = 1'b1;
        case (inst_w.i.funct3)
          `F3_ADD_SUB: alu_op_d = rv_core_pkg::ALU_ADD;
          `F3_SLL: begin
            alu_op_d = rv_core_pkg::ALU_SLL;
            imm_d    = imm_shamt;
            legal_d  = f7_base;
          end
          `F3_SRL_SRA: begin
            alu_op_d = f7_alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            imm_d    = imm_shamt;
            legal_d  = f7_base || f7_alt;
          end
          `F3_SLT:  alu_op_d = rv_core_pkg::ALU_SLT;
          `F3_SLTU: alu_op_d = rv_core_pkg::ALU_SLTU;
          `F3_XOR:  alu_op_d = rv_core_pkg::ALU_XOR;
          `F3_OR:   alu_op_d = rv_core_pkg::ALU_OR;
          default:  alu_op_d = rv_core_pkg::ALU_AND;
        endcase
      end
      `OPC_LUI: begin
        alu_op_d  = rv_core_pkg::ALU_PASS_B;
        imm_d     = {inst_w.u.imm20, 12'b0};
        use_imm_d = 1'b1;
        legal_d   = 1'b1;
      end
      default: legal_d = 1'b0; // unknown opcode
    endcase
  end

  // control flags clear on idle cycles
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_valid_o   <= 1'b0;
      dec_wen_o     <= 1'b0;
      dec_illegal_o <= 1'b0;
    end else begin
      dec_valid_o   <= inst_valid_i;
      dec_wen_o     <= inst_valid_i && legal_d && (rd_d != '0); // x0 never written
      dec_illegal_o <= inst_valid_i && !legal_d;
    end
  end

  // payload fields
  always_ff @(posedge clk) begin
    if (inst_valid_i) begin
      dec_alu_op_o  <= alu_op_d;
      dec_rs1_o     <= rs1_d;
      dec_rs2_o     <= rs2_d;
      dec_rd_o      <= rd_d;
      dec_imm_o     <= imm_d;
      dec_use_imm_o <= use_imm_d;
    end
  end

endmodule

/* rv_execute.sv */
`include "rv_core_defines.svh"

module rv_execute (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   dec_valid_i,
  input  rv_core_pkg::alu_op_e   dec_alu_op_i,
  input  logic [`REG_ADDR_W-1:0] dec_rs1_i,
  input  logic [`REG_ADDR_W-1:0] dec_rs2_i,
  input  logic [`REG_ADDR_W-1:0] dec_rd_i,
  input  logic [`XLEN-1:0]       dec_imm_i,
  input  logic                   dec_use_imm_i,
  input  logic                   dec_wen_i,
  input  logic                   dec_illegal_i,
  input  logic [`XLEN-1:0]       rs1_data_i,
  input  logic [`XLEN-1:0]       rs2_data_i,
  output logic                   ex_valid_o,
  output logic [`REG_ADDR_W-1:0] ex_rd_o,
  output logic                   ex_wen_o,
  output logic [`XLEN-1:0]       ex_result_o,
  output logic                   ex_illegal_o
);

  logic [`XLEN-1:0]    op_a;
  logic [`XLEN-1:0]    rs2_val;
  logic [`XLEN-1:0]    op_b;
  logic [`SHAMT_W-1:0] shamt;
  logic [`XLEN-1:0]    alu_result;

  // previous instruction not yet in the register file, take it from ex reg
  assign op_a    = (ex_wen_o && (ex_rd_o == dec_rs1_i)) ? ex_result_o : rs1_data_i;
  assign rs2_val = (ex_wen_o && (ex_rd_o == dec_rs2_i)) ? ex_result_o : rs2_data_i;

  assign op_b  = dec_use_imm_i ? dec_imm_i : rs2_val;
  assign shamt = op_b[`SHAMT_W-1:0];

  always_comb begin
    case (dec_alu_op_i)
      rv_core_pkg::ALU_ADD:    alu_result = op_a + op_b;
      rv_core_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv_core_pkg::ALU_SLL:    alu_result = op_a << shamt;
      rv_core_pkg::ALU_SLT: begin
        alu_result = {{(`XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      end
      rv_core_pkg::ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, (op_a < op_b)};
      rv_core_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      rv_core_pkg::ALU_SRL:    alu_result = op_a >> shamt;
      rv_core_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt); // sign fill
      rv_core_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv_core_pkg::ALU_AND:    alu_result = op_a & op_b;
      rv_core_pkg::ALU_PASS_B: alu_result = op_b;
      default:                 alu_result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o   <= 1'b0;
      ex_wen_o     <= 1'b0;
      ex_illegal_o <= 1'b0;
    end else begin
      ex_valid_o   <= dec_valid_i;
      ex_wen_o     <= dec_valid_i && dec_wen_i; // also gates forwarding
      ex_illegal_o <= dec_valid_i && dec_illegal_i;
    end
  end

  // result and destination
  always_ff @(posedge clk) begin
    if (dec_valid_i) begin
      ex_rd_o     <= dec_rd_i;
      ex_result_o <= dec_illegal_i ? '0 : alu_result;
    end
  end

endmodule

/* rv_writeback.sv */
`include "rv_core_defines.svh"

module rv_writeback (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
  input  logic                   ex_valid_i,
  input  logic [`REG_ADDR_W-1:0] ex_rd_i,
  input  logic                   ex_wen_i,
  input  logic [`XLEN-1:0]       ex_result_i,
  input  logic                   ex_illegal_i,
  output logic [`XLEN-1:0]       rs1_data_o,
  output logic [`XLEN-1:0]       rs2_data_o,
  output logic                   retire_valid_o,
  output logic [`REG_ADDR_W-1:0] retire_rd_o,
  output logic                   retire_wen_o,
  output logic [`XLEN-1:0]       retire_data_o,
  output logic                   retire_illegal_o
);

  logic [`XLEN-1:0] regs [`NUM_REGS]; // x0 stays at its reset value
  logic             wr_en;

  assign wr_en = ex_valid_i && ex_wen_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[ex_rd_i] <= ex_result_i;
    end
  end

  // combinational read ports back to execute
  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      retire_valid_o   <= 1'b0;
      retire_wen_o     <= 1'b0;
      retire_illegal_o <= 1'b0;
    end else begin
      retire_valid_o   <= ex_valid_i;
      retire_wen_o     <= wr_en;
      retire_illegal_o <= ex_valid_i && ex_illegal_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i) begin
      retire_rd_o   <= ex_rd_i;
      retire_data_o <= ex_result_i; // already zero when illegal
    end
  end

endmodule

/* rv_core_top.sv */
`include "rv_core_defines.svh"

module rv_core_top (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   inst_valid_i,
  input  logic [`XLEN-1:0]       inst_i,
  output logic                   retire_valid_o,
  output logic [`REG_ADDR_W-1:0] retire_rd_o,
  output logic                   retire_wen_o,
  output logic [`XLEN-1:0]       retire_data_o,
  output logic                   retire_illegal_o
);

  // decode to execute
  logic                   dec_valid;
  rv_core_pkg::alu_op_e   dec_alu_op;
  logic [`REG_ADDR_W-1:0] dec_rs1;
  logic [`REG_ADDR_W-1:0] dec_rs2;
  logic [`REG_ADDR_W-1:0] dec_rd;
  logic [`XLEN-1:0]       dec_imm;
  logic                   dec_use_imm;
  logic                   dec_wen;
  logic                   dec_illegal;

  // register file read data
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  // execute to write-back
  logic                   ex_valid;
  logic [`REG_ADDR_W-1:0] ex_rd;
  logic                   ex_wen;
  logic [`XLEN-1:0]       ex_result;
  logic                   ex_illegal;

  rv_decode i_rv_decode (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .dec_valid_o   (dec_valid),
    .dec_alu_op_o  (dec_alu_op),
    .dec_rs1_o     (dec_rs1),
    .dec_rs2_o     (dec_rs2),
    .dec_rd_o      (dec_rd),
    .dec_imm_o     (dec_imm),
    .dec_use_imm_o (dec_use_imm),
    .dec_wen_o     (dec_wen),
    .dec_illegal_o (dec_illegal)
  );

  rv_execute i_rv_execute (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .dec_valid_i   (dec_valid),
    .dec_alu_op_i  (dec_alu_op),
    .dec_rs1_i     (dec_rs1),
    .dec_rs2_i     (dec_rs2),
    .dec_rd_i      (dec_rd),
    .dec_imm_i     (dec_imm),
    .dec_use_imm_i (dec_use_imm),
    .dec_wen_i     (dec_wen),
    .dec_illegal_i (dec_illegal),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .ex_valid_o    (ex_valid),
    .ex_rd_o       (ex_rd),
    .ex_wen_o      (ex_wen),
    .ex_result_o   (ex_result),
    .ex_illegal_o  (ex_illegal)
  );

  rv_writeback i_rv_writeback (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .rs1_addr_i       (dec_rs1),  // read ports driven straight from decode
    .rs2_addr_i       (dec_rs2),
    .ex_valid_i       (ex_valid),
    .ex_rd_i          (ex_rd),
    .ex_wen_i         (ex_wen),
    .ex_result_i      (ex_result),
    .ex_illegal_i     (ex_illegal),
    .rs1_data_o       (rs1_data),
    .rs2_data_o       (rs2_data),
    .retire_valid_o   (retire_valid_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wen_o     (retire_wen_o),
    .retire_data_o    (retire_data_o),
    .retire_illegal_o (retire_illegal_o)
  );

endmodule

/* tb_rv_core.sv */
`include "rv_core_defines.svh"

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0]            cyc;  // cycle count at which retire shows it
    logic [`REG_ADDR_W-1:0] rd;
    logic                   wen;
    logic [`XLEN-1:0]       data;
    logic                   illegal;
  } retire_t;

  logic                   clk;
  logic                   arst_n_i;
  logic                   inst_valid_i;
  logic [`XLEN-1:0]       inst_i;
  logic                   retire_valid_o;
  logic [`REG_ADDR_W-1:0] retire_rd_o;
  logic                   retire_wen_o;
  logic [`XLEN-1:0]       retire_data_o;
  logic                   retire_illegal_o;

  logic [31:0]      cyc;
  logic [`XLEN-1:0] ref_regs [`NUM_REGS];
  retire_t          exp_q [$];
  retire_t          exp_r;      // expected retire outputs this cycle
  logic             exp_valid;

  rv_core_top i_rv_core_top (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .inst_valid_i     (inst_valid_i),
    .inst_i           (inst_i),
    .retire_valid_o   (retire_valid_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wen_o     (retire_wen_o),
    .retire_data_o    (retire_data_o),
    .retire_illegal_o (retire_illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    stop_with_failure($sformatf("[FAIL] %0t %s got 0x%08h expected 0x%08h",
                                $time, name, got, want));
  endtask

  // rv32i alu semantics where alt selects sub or sra
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      `F3_ADD_SUB: return alt ? a - b : a + b;
      `F3_SLL:     return a << b[4:0];
      `F3_SLT:     return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
      `F3_SLTU:    return {31'b0, a < b};
      `F3_XOR:     return a ^ b;
      `F3_SRL_SRA: return (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
      `F3_OR:      return a | b;
      default:     return a & b;
    endcase
  endfunction

  function automatic void model_issue(input logic [31:0] word);
    rv_core_pkg::inst_u w;
    logic [31:0]        b;
    logic               shift;
    retire_t            e;
    w = word;
    shift = (w.r.funct3 == `F3_SLL) || (w.r.funct3 == `F3_SRL_SRA);
    e.cyc = cyc + 3;  // accepted at the next edge and retired two edges later
    e.rd = w.r.rd;
    e.illegal = 1'b0;
    e.data = '0;
    case (w.r.opcode)
      `OPC_OP: begin
        e.illegal = !((w.r.funct7 == `F7_BASE) || ((w.r.funct7 == `F7_ALT) &&
                      (w.r.funct3 == `F3_ADD_SUB || w.r.funct3 == `F3_SRL_SRA)));
        e.data = ref_alu(w.r.funct3, w.r.funct7[5], ref_regs[w.r.rs1], ref_regs[w.r.rs2]);
      end
      `OPC_OP_IMM: begin
        b = shift ? {27'b0, w.r.rs2} : {{20{w.i.imm12[11]}}, w.i.imm12};
        e.illegal = shift && !((w.r.funct7 == `F7_BASE) ||
                               (w.r.funct7 == `F7_ALT && w.r.funct3 == `F3_SRL_SRA));
        e.data = ref_alu(w.i.funct3, shift && w.r.funct7[5], ref_regs[w.i.rs1], b);
      end
      `OPC_LUI: e.data = {w.u.imm20, 12'h000};
      default:  e.illegal = 1'b1;
    endcase
    if (e.illegal) begin
      e.data = '0;
    end
    e.wen = !e.illegal && (e.rd != '0);
    if (e.wen) begin
      ref_regs[e.rd] = e.data;  // issue order equals retire order
    end
    exp_q.push_back(e);
  endfunction

  function automatic logic [31:0] make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    rv_core_pkg::inst_u w;
    w.r.funct7 = f7;
    w.r.rs2 = rs2;
    w.r.rs1 = rs1;
    w.r.funct3 = f3;
    w.r.rd = rd;
    w.r.opcode = `OPC_OP;
    return w;
  endfunction

  function automatic logic [31:0] make_i(input logic [6:0] opc, input logic [11:0] imm,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    rv_core_pkg::inst_u w;
    w.i.imm12 = imm;
    w.i.rs1 = rs1;
    w.i.funct3 = f3;
    w.i.rd = rd;
    w.i.opcode = opc;
    return w;
  endfunction

  function automatic logic [31:0] make_u(input logic [19:0] imm, input logic [4:0] rd);
    rv_core_pkg::inst_u w;
    w.u.imm20 = imm;
    w.u.rd = rd;
    w.u.opcode = `OPC_LUI;
    return w;
  endfunction

  function automatic logic [31:0] rand_inst();
    logic [2:0]  f3;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [6:0]  f7;
    int unsigned kind;
    kind = $urandom_range(0, 9);
    f3 = 3'($urandom_range(0, 7));
    rs1 = 5'($urandom_range(0, 7));  // few registers give many dependences
    rs2 = 5'($urandom_range(0, 7));
    rd = 5'($urandom_range(0, 7));
    f7 = ((f3 == `F3_ADD_SUB || f3 == `F3_SRL_SRA) && $urandom_range(0, 1) == 1) ?
         `F7_ALT : `F7_BASE;
    case (kind)
      0, 1, 2, 3: return make_r(f7, rs2, rs1, f3, rd);
      4, 5, 6: return make_i(`OPC_OP_IMM, (f3 == `F3_SLL || f3 == `F3_SRL_SRA) ?
                             {f7, rs2} : 12'($urandom), rs1, f3, rd);
      7: return make_u(20'($urandom), rd);
      8: return make_i(7'b0000011, 12'($urandom), rs1, f3, rd);  // load opcode
      default: return make_r(7'b0000001, rs2, rs1, f3, rd);     // mul/div funct7
    endcase
  endfunction

  task automatic issue(input logic [31:0] word);
    inst_valid_i = 1'b1;
    inst_i = word;
    model_issue(word);
    @(posedge clk);
    #1;
    inst_valid_i = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // expected retire outputs move in step with the DUT
  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cyc       <= '0;
      exp_valid <= 1'b0;
      exp_r     <= '0;
    end else begin
      cyc       <= cyc + 1;
      exp_valid <= 1'b0;
      if (exp_q.size() != 0 && exp_q[0].cyc == cyc + 1) begin
        exp_valid <= 1'b1;
        exp_r     <= exp_q.pop_front();
      end
    end
  end

  a_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
    retire_valid_o == exp_valid)
    else report_mismatch("retire_valid_o", 32'($sampled(retire_valid_o)),
                         32'($sampled(exp_valid)));
  a_rd: assert property (@(posedge clk) disable iff (!arst_n_i)
    exp_valid |-> retire_rd_o == exp_r.rd)
    else report_mismatch("retire_rd_o", 32'($sampled(retire_rd_o)), 32'($sampled(exp_r.rd)));
  a_wen: assert property (@(posedge clk) disable iff (!arst_n_i)
    retire_wen_o == (exp_valid && exp_r.wen))
    else report_mismatch("retire_wen_o", 32'($sampled(retire_wen_o)),
                         32'($sampled(exp_valid && exp_r.wen)));
  a_data: assert property (@(posedge clk) disable iff (!arst_n_i)
    exp_valid |-> retire_data_o == exp_r.data)
    else report_mismatch("retire_data_o", $sampled(retire_data_o), $sampled(exp_r.data));
  a_illegal: assert property (@(posedge clk) disable iff (!arst_n_i)
    retire_illegal_o == (exp_valid && exp_r.illegal))
    else report_mismatch("retire_illegal_o", 32'($sampled(retire_illegal_o)),
                         32'($sampled(exp_valid && exp_r.illegal)));
  a_illegal_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
    retire_illegal_o |-> !retire_wen_o && retire_data_o == '0)
    else stop_with_failure("illegal instruction retired with a write or nonzero data");

  initial begin
    int n;
    void'($urandom(32'ha9e3_2bfc));
    inst_valid_i = 1'b0;
    inst_i = '0;
    arst_n_i = 1'b0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    idle(4);  // retire must stay quiet
    issue(make_i(`OPC_OP_IMM, 12'hffb, 5'd0, `F3_ADD_SUB, 5'd1));  // x1 = -5
    issue(make_i(`OPC_OP_IMM, 12'h7ff, 5'd0, `F3_ADD_SUB, 5'd2));
    issue(make_u(20'h80000, 5'd3));
    issue(make_u(20'habcde, 5'd4));
    // all R-type ops back to back and chained through x5
    issue(make_r(`F7_BASE, 5'd2, 5'd1, `F3_ADD_SUB, 5'd5));
    issue(make_r(`F7_ALT, 5'd1, 5'd5, `F3_ADD_SUB, 5'd5));
    issue(make_r(`F7_BASE, 5'd2, 5'd5, `F3_SLL, 5'd5));
    issue(make_r(`F7_BASE, 5'd2, 5'd1, `F3_SLT, 5'd6));
    issue(make_r(`F7_BASE, 5'd2, 5'd1, `F3_SLTU, 5'd7));
    issue(make_r(`F7_BASE, 5'd4, 5'd5, `F3_XOR, 5'd5));
    issue(make_r(`F7_BASE, 5'd1, 5'd3, `F3_SRL_SRA, 5'd8));
    issue(make_r(`F7_ALT, 5'd1, 5'd3, `F3_SRL_SRA, 5'd9));   // sign fill
    issue(make_r(`F7_BASE, 5'd9, 5'd5, `F3_OR, 5'd5));
    issue(make_r(`F7_BASE, 5'd4, 5'd5, `F3_AND, 5'd5));
    // I-type ops partly with a one-cycle gap
    issue(make_i(`OPC_OP_IMM, 12'h800, 5'd5, `F3_ADD_SUB, 5'd10));
    idle(1);
    issue(make_i(`OPC_OP_IMM, 12'hfff, 5'd10, `F3_SLT, 5'd11));
    issue(make_i(`OPC_OP_IMM, 12'hfff, 5'd10, `F3_SLTU, 5'd12));
    idle(1);
    issue(make_i(`OPC_OP_IMM, 12'h555, 5'd10, `F3_XOR, 5'd10));
    issue(make_i(`OPC_OP_IMM, 12'h0f0, 5'd10, `F3_OR, 5'd10));
    idle(1);
    issue(make_i(`OPC_OP_IMM, 12'hf0f, 5'd10, `F3_AND, 5'd10));
    issue(make_i(`OPC_OP_IMM, {`F7_BASE, 5'd4}, 5'd10, `F3_SLL, 5'd13));
    issue(make_i(`OPC_OP_IMM, {`F7_BASE, 5'd7}, 5'd3, `F3_SRL_SRA, 5'd14));
    issue(make_i(`OPC_OP_IMM, {`F7_ALT, 5'd7}, 5'd3, `F3_SRL_SRA, 5'd15));
    // x0 as destination and then as source
    issue(make_i(`OPC_OP_IMM, 12'h123, 5'd1, `F3_ADD_SUB, 5'd0));
    issue(make_r(`F7_BASE, 5'd0, 5'd0, `F3_OR, 5'd16));
    // illegal encodings aimed at x1 before x1 is read back
    issue(make_i(7'b1111111, 12'h001, 5'd2, `F3_ADD_SUB, 5'd1));
    issue(make_r(`F7_ALT, 5'd2, 5'd2, `F3_XOR, 5'd1));
    issue(make_i(`OPC_OP_IMM, {`F7_ALT, 5'd3}, 5'd2, `F3_SLL, 5'd1));
    issue(make_i(`OPC_OP_IMM, 12'h000, 5'd1, `F3_ADD_SUB, 5'd17));
    for (int k = 0; k < 300; k++) begin
      issue(rand_inst());
      idle($urandom_range(0, 2));
    end
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      stop_with_failure("timeout waiting for the last instructions to retire");
    end else begin
      idle(2);  // let the last retirement be checked
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

/* flist.f */
+incdir+.
rv_core_pkg.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_core_top.sv
tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= TESTS PASSED
RTL_SRCS  ?= rv_core_pkg.sv rv_decode.sv rv_execute.sv rv_writeback.sv rv_core_top.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall +incdir+. --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) --binary --timing --assert --timescale 1ns/1ps -f $(FLIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR) $(VFLAGS)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
